//--- build.f
hdl/dcache_geom_pkg.sv
hdl/dcache_bus_pkg.sv
hdl/cache_array.sv
hdl/refill_buffer.sv
hdl/store_merge.sv
hdl/dcache_ctrl.sv
hdl/l1_dcache.sv
testbench/tb_mem_model.sv
testbench/tb_l1_dcache.sv

//--- hdl/cache_array.sv
// Cache storage array
// 64 entries, registered read, byte-masked write, cleared on reset

`timescale 1ns/100ps

module cache_array #(
  parameter type entry_t = dcache_geom_pkg::line_t
) (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic [dcache_geom_pkg::index_bits-1:0] index,
  input  logic                                   we,
  input  logic [15:0]                            be,
  input  entry_t                                 wdata,
  output entry_t                                 rdata
);

  localparam int entry_bits = $bits(entry_t);

  logic [entry_bits-1:0] mem_q [dcache_geom_pkg::num_lines];
  logic [entry_bits-1:0] rd_q;
  logic [entry_bits-1:0] bit_mask;

  always_comb
  begin
    for (int i = 0; i < entry_bits; i++)
      bit_mask[i] = be[i/8];  // Byte enable spread to bits
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      for (int i = 0; i < dcache_geom_pkg::num_lines; i++)
        mem_q[i] <= '0;
      rd_q <= '0;
    end
    else
    begin
      if (we)
        mem_q[index] <= (mem_q[index] & ~bit_mask) | (wdata & bit_mask);
      rd_q <= mem_q[index];  // Old contents on a same-cycle write
    end
  end

  assign rdata = entry_t'(rd_q);

endmodule

//--- hdl/dcache_bus_pkg.sv
// Core-side and memory-side request formats of the data cache

package dcache_bus_pkg;

  // Store and transfer width
  typedef enum logic [1:0] {
    size_byte = 2'd0,
    size_half = 2'd1,
    size_word = 2'd2
  } access_size_t;

  // Request from the core, held stable while core_wait is high
  typedef struct packed {
    logic                                  req;
    logic                                  write;
    logic [dcache_geom_pkg::word_bits-1:0] addr;
    logic [dcache_geom_pkg::word_bits-1:0] wdata;
    access_size_t                          size;
  } core_req_t;

  // Request to memory, held until a cycle with mem_wait low
  typedef struct packed {
    logic                                  req;
    logic                                  write;
    logic [dcache_geom_pkg::word_bits-1:0] addr;
    logic [dcache_geom_pkg::word_bits-1:0] wdata;
    access_size_t                          size;
  } mem_req_t;

endpackage

//--- hdl/dcache_ctrl.sv
// Data cache controller
// Lookup, four-beat refill, line fill and write-through sequencing

`timescale 1ns/100ps

module dcache_ctrl (
  input  logic                                   clk,
  input  logic                                   rst,
  input  dcache_bus_pkg::core_req_t              core,
  output logic                                   core_wait,
  output logic                                   use_refill_word,
  input  dcache_geom_pkg::tag_entry_t            tag_rd,
  output logic [dcache_geom_pkg::word_bits-1:0]  hit_word,
  input  dcache_geom_pkg::line_t                 line_rd,
  output logic [dcache_geom_pkg::index_bits-1:0] array_index,
  output logic                                   tag_we,
  output dcache_geom_pkg::tag_entry_t            tag_wr,
  output logic [15:0]                            data_be,
  output dcache_geom_pkg::line_t                 data_wr,
  input  dcache_geom_pkg::line_t                 refill_line,
  output logic                                   beat_done,
  output logic [1:0]                             beat_num,
  input  dcache_geom_pkg::line_t                 merged_line,
  input  logic [15:0]                            merge_be,
  output dcache_bus_pkg::mem_req_t               mem,
  input  logic                                   mem_wait
);

  localparam int word_bits = dcache_geom_pkg::word_bits;
  localparam int byte_sel_bits = dcache_geom_pkg::offset_bits - 2;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_refill,
    st_fill,
    st_write_through
  } state_t;

  state_t                        state_q, state_d;
  dcache_bus_pkg::core_req_t     req_q;
  dcache_geom_pkg::addr_fields_t req_f;
  dcache_geom_pkg::addr_fields_t core_f;
  logic [1:0]                    beat_q;
  logic                          hit;

  assign req_f  = req_q.addr;
  assign core_f = core.addr;

  assign hit         = tag_rd.valid && (tag_rd.tag == req_f.tag);
  assign hit_word    = line_rd[req_f.word_sel*word_bits +: word_bits];
  assign array_index = (state_q == st_idle) ? core_f.index : req_f.index;
  assign tag_wr      = '{valid: 1'b1, tag: req_f.tag};
  assign data_wr     = (state_q == st_fill) ? refill_line : merged_line;
  assign beat_num    = beat_q;

  // ====================================================================
  // State and request registers
  // ====================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q <= st_idle;
      beat_q  <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == st_lookup)
        beat_q <= '0;
      else if (beat_done)
        beat_q <= beat_q + 2'd1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state_q == st_idle && core.req)
      req_q <= core;
  end

  // ====================================================================
  // Next state and outputs
  // ====================================================================
  always_comb
  begin
    state_d         = state_q;
    core_wait       = 1'b0;
    use_refill_word = 1'b0;
    tag_we          = 1'b0;
    data_be         = '0;
    beat_done       = 1'b0;
    mem             = '0;
    case (state_q)
      st_idle:
      begin
        if (core.req)
        begin
          core_wait = 1'b1;
          state_d   = st_lookup;
        end
      end
      st_lookup:
      begin
        if (req_q.write)
        begin
          core_wait = 1'b1;
          state_d   = st_write_through;
          if (hit)
            data_be = merge_be;  // Store merged into the line
        end
        else if (hit)
          state_d = st_idle;  // Hit word returned now
        else
        begin
          core_wait = 1'b1;
          state_d   = st_refill;
        end
      end
      st_refill:
      begin
        core_wait = 1'b1;
        mem.req   = 1'b1;
        mem.size  = dcache_bus_pkg::size_word;
        mem.addr  = {req_f.tag, req_f.index, beat_q, {byte_sel_bits{1'b0}}};
        if (!mem_wait)
        begin
          beat_done = 1'b1;
          if (beat_q == 2'd3)
            state_d = st_fill;
        end
      end
      st_fill:
      begin
        use_refill_word = 1'b1;
        tag_we          = 1'b1;
        data_be         = '1;
        state_d         = st_idle;
      end
      st_write_through:
      begin
        core_wait = mem_wait;
        mem.req   = 1'b1;
        mem.write = 1'b1;
        mem.addr  = req_q.addr;
        mem.wdata = req_q.wdata;
        mem.size  = req_q.size;
        if (!mem_wait)
          state_d = st_idle;
      end
      default:
        state_d = st_idle;
    endcase
  end

endmodule

//--- hdl/dcache_geom_pkg.sv
// Data cache geometry
// Direct-mapped, 64 lines of 16 bytes, 32-bit address and word

package dcache_geom_pkg;

  localparam int index_bits     = 6;
  localparam int offset_bits    = 4;
  localparam int tag_bits       = 22;
  localparam int num_lines      = 64;
  localparam int words_per_line = 4;
  localparam int word_bits      = 32;
  localparam int line_bits      = 128;

  // One tag RAM entry, valid kept beside the tag
  typedef struct packed {
    logic                valid;
    logic [tag_bits-1:0] tag;
  } tag_entry_t;

  typedef logic [line_bits-1:0] line_t;

  // Overlay on a byte address, msb first
  typedef struct packed {
    logic [tag_bits-1:0]                tag;
    logic [index_bits-1:0]              index;
    logic [$clog2(words_per_line)-1:0]  word_sel;
    logic [offset_bits-$clog2(words_per_line)-1:0] byte_sel;
  } addr_fields_t;

endpackage

//--- hdl/l1_dcache.sv
// L1 data cache top level
// Controller, tag and data arrays, refill buffer and store merge

`timescale 1ns/100ps

module l1_dcache (
  input  logic                                  clk,
  input  logic                                  rst,
  input  dcache_bus_pkg::core_req_t             core,
  output logic [dcache_geom_pkg::word_bits-1:0] core_rdata,
  output logic                                  core_wait,
  output dcache_bus_pkg::mem_req_t              mem,
  input  logic [dcache_geom_pkg::word_bits-1:0] mem_rdata,
  input  logic                                  mem_wait
);

  dcache_geom_pkg::addr_fields_t          core_f;
  dcache_geom_pkg::tag_entry_t            tag_rd;
  dcache_geom_pkg::tag_entry_t            tag_wr;
  dcache_geom_pkg::line_t                 line_rd;
  dcache_geom_pkg::line_t                 data_wr;
  dcache_geom_pkg::line_t                 refill_line;
  dcache_geom_pkg::line_t                 merged_line;
  logic [dcache_geom_pkg::index_bits-1:0] array_index;
  logic                                   tag_we;
  logic [15:0]                            data_be;
  logic [15:0]                            merge_be;
  logic                                   beat_done;
  logic [1:0]                             beat_num;
  logic                                   use_refill_word;
  logic [dcache_geom_pkg::word_bits-1:0]  hit_word;
  logic [dcache_geom_pkg::word_bits-1:0]  refill_word;

  assign core_f     = core.addr;
  assign core_rdata = use_refill_word ? refill_word : hit_word;

  dcache_ctrl dcache_ctrl_inst (
    .clk, .rst, .core, .core_wait, .use_refill_word, .tag_rd, .hit_word,
    .line_rd, .array_index, .tag_we, .tag_wr, .data_be, .data_wr, .refill_line,
    .beat_done, .beat_num, .merged_line, .merge_be, .mem, .mem_wait
  );

  cache_array #(.entry_t(dcache_geom_pkg::tag_entry_t)) tag_array (
    .clk, .rst, .index(array_index), .we(tag_we), .be(16'hffff),
    .wdata(tag_wr), .rdata(tag_rd)
  );

  // Write enable is the byte mask alone
  cache_array #(.entry_t(dcache_geom_pkg::line_t)) data_array (
    .clk, .rst, .index(array_index), .we(1'b1), .be(data_be),
    .wdata(data_wr), .rdata(line_rd)
  );

  refill_buffer refill_buffer_inst (
    .clk, .rst, .beat_done, .beat_num, .mem_rdata, .want_word(core_f.word_sel),
    .line(refill_line), .word(refill_word)
  );

  store_merge store_merge_inst (
    .core, .line_in(line_rd), .line_out(merged_line), .be(merge_be)
  );

endmodule

//--- hdl/refill_buffer.sv
// Refill buffer
// Collects the four word beats of a line fill and keeps the word
// the core asked for

`timescale 1ns/100ps

module refill_buffer (
  input  logic                                               clk,
  input  logic                                               rst,
  input  logic                                               beat_done,
  input  logic [$clog2(dcache_geom_pkg::words_per_line)-1:0] beat_num,
  input  logic [dcache_geom_pkg::word_bits-1:0]              mem_rdata,
  input  logic [$clog2(dcache_geom_pkg::words_per_line)-1:0] want_word,
  output dcache_geom_pkg::line_t                             line,
  output logic [dcache_geom_pkg::word_bits-1:0]              word
);

  localparam int word_bits = dcache_geom_pkg::word_bits;
  localparam int line_bits = dcache_geom_pkg::line_bits;

  dcache_geom_pkg::line_t        line_q;
  logic [word_bits-1:0]          word_q;

  // ====================================================================
  // Beats arrive base first, so each one enters at the top and the
  // first beat ends up in word 0 after the fourth
  // ====================================================================
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      line_q <= '0;
      word_q <= '0;
    end
    else if (beat_done)
    begin
      line_q <= {mem_rdata, line_q[line_bits-1:word_bits]};
      if (beat_num == want_word)
        word_q <= mem_rdata;  // Forwarded word
    end
  end

  assign line = line_q;
  assign word = word_q;

endmodule

//--- hdl/store_merge.sv
// Store merge
// Turns a core store into line byte enables and lane-placed data,
// and overlays it on the line read from the data array

`timescale 1ns/100ps

module store_merge (
  input  dcache_bus_pkg::core_req_t                     core,
  input  dcache_geom_pkg::line_t                        line_in,
  output dcache_geom_pkg::line_t                        line_out,
  output logic [dcache_geom_pkg::line_bits/8-1:0]       be
);

  localparam int line_bytes = dcache_geom_pkg::line_bits / 8;

  dcache_geom_pkg::addr_fields_t   fields;
  logic [3:0]                      lane_be;
  logic [31:0]                     lane_data;
  dcache_geom_pkg::line_t          store_line;

  assign fields = core.addr;

  always_comb
  begin
    case (core.size)
      dcache_bus_pkg::size_byte:
      begin
        lane_be   = 4'b0001 << fields.byte_sel;
        lane_data = {4{core.wdata[7:0]}};
      end
      dcache_bus_pkg::size_half:
      begin
        lane_be   = fields.byte_sel[1] ? 4'b1100 : 4'b0011;  // Upper or lower half
        lane_data = {2{core.wdata[15:0]}};
      end
      default:
      begin
        lane_be   = 4'b1111;
        lane_data = core.wdata;
      end
    endcase
  end

  assign be         = {12'd0, lane_be} << {fields.word_sel, 2'b00};
  assign store_line = {4{lane_data}};

  always_comb
  begin
    for (int i = 0; i < line_bytes; i++)
      line_out[i*8 +: 8] = be[i] ? store_line[i*8 +: 8] : line_in[i*8 +: 8];
  end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the L1 data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_l1_dcache \
  -o tb_l1_dcache_sim \
  && ./obj_dir/tb_l1_dcache_sim | tee /dev/stderr | grep -q '\*\*\* TEST PASSED \*\*\*' \
  && echo "Simulation result: pass" \
  || { echo "Simulation result: fail"; exit 1; }

//--- testbench/tb_l1_dcache.sv
// Testbench for the L1 data cache
// Directed read, store and eviction tests against a reference copy of memory

`timescale 1ns/100ps

module tb_l1_dcache;

  localparam int cycle_limit = 4000;  // ~40 requests at ~30 cycles each, with margin

  logic                      clk;
  logic                      rst;
  dcache_bus_pkg::core_req_t core;
  logic [31:0]               core_rdata;
  logic                      core_wait;
  dcache_bus_pkg::mem_req_t  mem;
  logic [31:0]               mem_rdata;
  logic                      mem_wait;

  int                        seed = 32'h6308b2a0;
  int                        cycle_count;
  int                        check_count;
  int                        value_errors;
  int                        protocol_errors;
  logic [31:0]               ref_mem [logic [29:0]];  // Stores seen so far
  logic                      mem_held = 1'b0;
  dcache_bus_pkg::mem_req_t  mem_prev;

  l1_dcache l1_dcache_inst (
    .clk, .rst, .core, .core_rdata, .core_wait, .mem, .mem_rdata, .mem_wait
  );

  tb_mem_model mem_model_inst (
    .clk, .rst, .mem, .mem_rdata, .mem_wait
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ====================================================================
  // Reference values
  // ====================================================================
  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h5a3c96e1;
  endfunction

  function automatic logic [31:0] expected_word(input logic [31:0] addr);
    if (ref_mem.exists(addr[31:2]))
      return ref_mem[addr[31:2]];
    return fill_pattern({addr[31:2], 2'b00});
  endfunction

  function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [31:0] addr,
                                              input logic [31:0] wdata,
                                              input dcache_bus_pkg::access_size_t acc_size);
    logic [31:0] w;
    w = old;
    if (acc_size == dcache_bus_pkg::size_byte)
      w[{addr[1:0], 3'b000} +: 8] = wdata[7:0];
    else if (acc_size == dcache_bus_pkg::size_half)
      w[{addr[1], 4'b0000} +: 16] = wdata[15:0];  // addr[1] picks the half
    else
      w = wdata;
    return w;
  endfunction

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] expected);
    check_count++;
    if (got !== expected)
    begin
      value_errors++;
      $display("FAILED %s: got %h, expected %h", name, got, expected);
    end
  endtask

  // ====================================================================
  // Core requests
  // ====================================================================
  task automatic issue_request(input logic is_write, input logic [31:0] addr,
                               input logic [31:0] wdata,
                               input dcache_bus_pkg::access_size_t acc_size,
                               output logic [31:0] rdata, output int latency,
                               output int first_xfer);
    first_xfer = mem_model_inst.log_count;
    core <= '{req: 1'b1, write: is_write, addr: addr, wdata: wdata, size: acc_size};
    @(posedge clk);
    compare("core_wait", 32'(core_wait), 32'd1);  // High in the acceptance cycle
    latency = 0;
    do
    begin
      @(posedge clk);
      latency++;
    end
    while (core_wait);
    rdata = core_rdata;
    core <= '0;
    @(posedge clk);
  endtask

  task automatic verify_refill(input int first, input logic [31:0] line_base);
    dcache_bus_pkg::mem_req_t xfer;
    compare("transfer count", mem_model_inst.log_count - first, 32'd4);
    for (int k = 0; k < 4; k++)
    begin
      xfer = mem_model_inst.log_q[first + k];
      compare("mem.write", 32'(xfer.write), 32'd0);
      compare("mem.addr", xfer.addr, line_base + 32'(4 * k));
      compare("mem.size", 32'(xfer.size), 32'(dcache_bus_pkg::size_word));
    end
  endtask

  task automatic load_expect(input logic [31:0] addr, input logic expect_miss);
    logic [31:0] rdata;
    int          latency;
    int          first;
    issue_request(1'b0, addr, 32'd0, dcache_bus_pkg::size_word, rdata, latency, first);
    compare("core_rdata", rdata, expected_word(addr));
    if (expect_miss)
      verify_refill(first, {addr[31:4], 4'h0});
    else
    begin
      compare("transfer count", mem_model_inst.log_count - first, 32'd0);
      compare("hit latency", latency, 32'd1);
    end
  endtask

  task automatic store_expect(input logic [31:0] addr, input logic [31:0] wdata,
                              input dcache_bus_pkg::access_size_t acc_size);
    logic [31:0]              rdata;
    int                       latency;
    int                       first;
    dcache_bus_pkg::mem_req_t xfer;
    issue_request(1'b1, addr, wdata, acc_size, rdata, latency, first);
    compare("transfer count", mem_model_inst.log_count - first, 32'd1);
    xfer = mem_model_inst.log_q[first];
    compare("mem.write", 32'(xfer.write), 32'd1);
    compare("mem.addr", xfer.addr, addr);
    compare("mem.wdata", xfer.wdata, wdata);
    compare("mem.size", 32'(xfer.size), 32'(acc_size));
    ref_mem[addr[31:2]] = merge_store(expected_word(addr), addr, wdata, acc_size);
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic first_miss_after_reset();
    compare("core_wait", 32'(core_wait), 32'd0);
    compare("mem.req", 32'(mem.req), 32'd0);
    load_expect(32'h0000_1238, 1'b1);
  endtask

  task automatic miss_each_offset();
    for (int i = 0; i < 4; i++)
      load_expect(32'h0000_2000 + 32'(i * 20), 1'b1);  // New line, next word offset
  endtask

  task automatic hits_in_line();
    for (int i = 0; i < 4; i++)
      load_expect(32'h0000_1230 + 32'(i * 4), 1'b0);
  endtask

  task automatic stores_that_hit();
    store_expect(32'h0000_1231, 32'hdead_be5a, dcache_bus_pkg::size_byte);
    load_expect(32'h0000_1230, 1'b0);
    store_expect(32'h0000_1236, 32'h1357_c0de, dcache_bus_pkg::size_half);
    load_expect(32'h0000_1234, 1'b0);
    store_expect(32'h0000_123c, 32'h8bad_f00d, dcache_bus_pkg::size_word);
    load_expect(32'h0000_123c, 1'b0);
  endtask

  task automatic store_miss_no_allocate();
    store_expect(32'h0000_3346, 32'h0000_a55a, dcache_bus_pkg::size_half);
    load_expect(32'h0000_3344, 1'b1);
    store_expect(32'h0000_3353, 32'h0000_00c3, dcache_bus_pkg::size_byte);
    load_expect(32'h0000_3350, 1'b1);
  endtask

  // Same index 0x11, tags differ
  task automatic conflict_eviction();
    logic [31:0] base;
    logic [31:0] addr;
    logic [31:0] resident;
    logic [31:0] wdata;
    int          r;
    resident = 32'hffff_ffff;
    for (int i = 0; i < 16; i++)
    begin
      r     = $random(seed);
      wdata = $random(seed);
      base  = r[6] ? 32'h0000_4910 : 32'h0000_4510;
      addr  = base + {28'd0, r[3:2], 2'b00};
      if (r[5:4] == 2'd0)
        store_expect(addr, wdata, r[8] ? dcache_bus_pkg::size_word : dcache_bus_pkg::size_byte);
      else
      begin
        load_expect(addr, resident != base);
        resident = base;
      end
    end
  endtask

  // ====================================================================
  // Monitors and run control
  // ====================================================================
  always @(posedge clk)
  begin
    if (!rst && mem_held && mem !== mem_prev)
    begin
      protocol_errors++;
      $display("Memory request changed while mem_wait was high, cycle %0d", cycle_count);
    end
    mem_held <= mem.req && mem_wait;
    mem_prev <= mem;
  end

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial
  begin
    rst  = 1'b1;
    core = '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    first_miss_after_reset();
    miss_each_offset();
    hits_in_line();
    stores_that_hit();
    store_miss_no_allocate();
    conflict_eviction();
    $display("Checks: %0d, value errors: %0d, protocol errors: %0d",
             check_count, value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

//--- testbench/tb_mem_model.sv
// Backing memory for the data cache testbench
// Word store over an address fill pattern, random wait states of 0 to 3
// cycles and a log of every completed transfer

`timescale 1ns/100ps

module tb_mem_model (
  input  logic                     clk,
  input  logic                     rst,
  input  dcache_bus_pkg::mem_req_t mem,
  output logic [31:0]              mem_rdata,
  output logic                     mem_wait
);

  int                       seed = 32'h6308b2a0;
  logic [31:0]              store_q [logic [29:0]];  // Words written so far
  logic [1:0]               wait_q;
  dcache_bus_pkg::mem_req_t log_q [0:255];
  int                       log_count;

  function automatic logic [31:0] fill_pattern(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'h5a3c96e1;
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    if (store_q.exists(addr[31:2]))
      return store_q[addr[31:2]];
    return fill_pattern({addr[31:2], 2'b00});
  endfunction

  // Little-endian lanes from the low address bits
  function automatic logic [31:0] apply_lanes(input logic [31:0] old, input logic [31:0] addr,
                                              input logic [31:0] wdata,
                                              input dcache_bus_pkg::access_size_t acc_size);
    logic [31:0] w;
    w = old;
    case (acc_size)
      dcache_bus_pkg::size_byte: w[{addr[1:0], 3'b000} +: 8] = wdata[7:0];
      dcache_bus_pkg::size_half: w[{addr[1], 4'b0000} +: 16] = wdata[15:0];
      default: w = wdata;
    endcase
    return w;
  endfunction

  assign mem_wait = mem.req && (wait_q != 2'd0);

  always_comb
  begin
    mem_rdata = read_word(mem.addr);
  end

  // ====================================================================
  // Transfer on a cycle with no wait left, then draw the next delay
  // ====================================================================
  always @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      wait_q    <= 2'd0;
      log_count <= 0;
    end
    else if (mem.req)
    begin
      if (wait_q != 2'd0)
        wait_q <= wait_q - 2'd1;
      else
      begin
        if (mem.write)
          store_q[mem.addr[31:2]] = apply_lanes(read_word(mem.addr), mem.addr, mem.wdata,
                                                mem.size);
        log_q[log_count[7:0]] <= mem;
        log_count             <= log_count + 1;
        wait_q                <= 2'($random(seed) & 32'd3);
      end
    end
  end

endmodule
